/* testbench/cpu_input.dat */
# P: doubleword address, instruction doubleword (upper word at address+4)
# S: expected store address and data, in order; C: expected character code, in order
P 0000 123450b720000113  # lui x1 | addi x2,0x200
P 0008 ffb0019300113023  # addi x3,-5 | sd x1
P 0010 0640021300313423  # addi x4,100 | sd x3
P 0018 00513823003202b3  # sd x5 | add x5
P 0020 00613c2340418333  # sd x6 | sub x6
P 0028 027130230041f3b3  # sd x7 | and x7
P 0030 028134230040e433  # sd x8 | or x8
P 0038 029138230041c4b3  # sd x9 | xor x9
P 0040 02b13c230041a5b3  # sd x11 | slt x11
P 0048 04c1302300322633  # sd x12 | slt x12
P 0050 04d1342300813683  # sd x13 | ld x13
P 0058 0401382300700013  # sd x0 | addi x0,7
P 0060 04313c2300420463  # marker | beq taken
P 0068 0631302300321463  # marker | bne taken
P 0070 04413c2300320463  # sd x4 | beq not taken
P 0078 063130230080076f  # marker | jal x14
P 0080 04f0051306e13023  # addi x10 | sd x14
P 0088 04b005130000007b  # addi x10 | putch
P 0090 10a005130000007b  # addi x10 | putch
P 0098 0000006f0000007b  # jal self | putch
S 0200 0000000012345000
S 0208 fffffffffffffffb
S 0210 000000000000005f
S 0218 ffffffffffffff97
S 0220 0000000000000060
S 0228 0000000012345064
S 0230 ffffffffffffff9f
S 0238 0000000000000001
S 0240 0000000000000000
S 0248 fffffffffffffffb
S 0250 0000000000000000
S 0258 0000000000000064
S 0260 000000000000007c
C 4f
C 4b
C 0a

/* all.f */
+incdir+include
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/exec_unit.sv
hw/load_store_unit.sv
hw/regfile.sv
hw/bus_arbiter.sv
hw/cpu_top.sv
testbench/clock_gen.sv
testbench/cpu_chk.sv
testbench/cpu_tb.sv

/* testbench/cpu_tb.sv */
// testbench for cpu_top: memory model, program and expected results from the input file
`default_nettype none
`include "core_macros.svh"

module cpu_tb;
  import core_pkg::*;

  localparam int MEM_WORDS = 256;

  logic             clk;
  logic             i_rst;
  logic             mem_valid;
  mem_req_t         mem_req;
  logic             mem_ready;
  logic [`XLEN-1:0] mem_rdata;
  logic             putch_valid;
  logic [7:0]       putch_char;

  logic [`XLEN-1:0] mem [MEM_WORDS];
  logic [`XLEN-1:0] exp_store_addr [$];
  logic [`XLEN-1:0] exp_store_data [$];
  logic [7:0]       exp_char [$];

  int   n_prog;
  int   store_idx;
  int   char_idx;
  int   mismatches;
  int   failures;
  int   delay;
  logic pending;
  logic first_seen;
  logic loaded;
  logic all_seen;

  clock_gen u_clk (
    .o_clk (clk)
  );

  cpu_top i_cpu_top (
    .clk           (clk),
    .i_rst         (i_rst),
    .o_mem_valid   (mem_valid),
    .o_mem_req     (mem_req),
    .i_mem_ready   (mem_ready),
    .i_mem_rdata   (mem_rdata),
    .o_putch_valid (putch_valid),
    .o_putch_char  (putch_char)
  );

  bind cpu_top cpu_chk u_chk (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_mem_valid   (o_mem_valid),
    .i_mem_req     (o_mem_req),
    .i_mem_ready   (i_mem_ready),
    .i_putch_valid (o_putch_valid)
  );

  //////////////////////////////
  // helpers

  task automatic compare_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    if (actual !== expected) begin
      mismatches++;
      $display("error: %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // byte address in the low half so every word differs
  function automatic logic [63:0] fill_word(input int unsigned k);
    return {32'hdead_beef, 32'(k * 8)};
  endfunction

  task automatic read_input_file();
    int          fd;
    int          n;
    string       line;
    byte         kind;
    logic [63:0] a;
    logic [63:0] d;
    for (int k = 0; k < MEM_WORDS; k++) begin
      mem[k] = fill_word(k);
    end
    fd = $fopen("testbench/cpu_input.dat", "r");
    if (fd == 0) begin
      failures++;
      $display("could not open the input file testbench/cpu_input.dat");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%c %h %h", kind, a, d);
      case (kind)
        "P": begin
          mem[a[10:3]] = d;
          n_prog++;
        end
        "S": begin
          exp_store_addr.push_back(a);
          exp_store_data.push_back(d);
        end
        "C": exp_char.push_back(a[7:0]);
        default: begin
          failures++;
          $display("unreadable line in the input file: %s", line);
        end
      endcase
    end
    $fclose(fd);
  endtask

  task automatic update_progress();
    all_seen = (store_idx >= exp_store_addr.size()) && (char_idx >= exp_char.size());
  endtask

  task automatic record_store(input logic [63:0] addr, input logic [63:0] data);
    if (store_idx >= exp_store_addr.size()) begin
      failures++;
      $display("unexpected extra store of %h to address %h", data, addr);
    end else begin
      compare_value($sformatf("store %0d address", store_idx), exp_store_addr[store_idx], addr);
      compare_value($sformatf("store %0d data", store_idx), exp_store_data[store_idx], data);
      store_idx++;
    end
    update_progress();
  endtask

  task automatic record_char(input logic [7:0] ch);
    if (char_idx >= exp_char.size()) begin
      failures++;
      $display("unexpected extra character %h", ch);
    end else begin
      compare_value($sformatf("character %0d", char_idx), exp_char[char_idx], ch);
      char_idx++;
    end
    update_progress();
  endtask

  // runs on the falling edge, ready and data apply to the next rising edge
  task automatic serve_memory();
    logic [`XLEN-1:0] addr;
    addr = mem_req.addr;
    mem_ready = 1'b0;
    if (putch_valid) begin
      record_char(putch_char);
    end
    if (!mem_valid) begin
      return;
    end
    if (!pending) begin
      delay = $urandom % 4;
      pending = 1'b1;
    end
    if (delay > 0) begin
      delay--;
      return;
    end
    pending = 1'b0;
    mem_ready = 1'b1;
    if (!first_seen) begin
      first_seen = 1'b1;
      compare_value("first request write flag", 64'd0, 64'(mem_req.write));
      compare_value("first request address", `RESET_PC, addr);
    end
    if (addr >= 64'(MEM_WORDS * 8)) begin
      failures++;
      $display("memory access at %h is outside the memory model", addr);
      mem_rdata = '0;
    end else if (mem_req.write) begin
      mem[addr[10:3]] = mem_req.wdata;
      record_store(addr, mem_req.wdata);
    end else begin
      mem_rdata = mem[addr[10:3]];
    end
  endtask

  task automatic print_summary();
    $display("errors: %0d mismatch, %0d other, %0d assertion, stores %0d/%0d, chars %0d/%0d",
             mismatches, failures, i_cpu_top.u_chk.fail_count,
             store_idx, exp_store_addr.size(), char_idx, exp_char.size());
  endtask

  //////////////////////////////
  // processes

  initial begin : memory_model
    void'($urandom(32'hb346_6169));
    mem_ready = 1'b0;
    mem_rdata = '0;
    pending = 1'b0;
    delay = 0;
    first_seen = 1'b0;
    forever begin
      @(negedge clk);
      serve_memory();
    end
  end

  initial begin : stimulus
    i_rst = 1'b1;
    loaded = 1'b0;
    all_seen = 1'b0;
    n_prog = 0;
    store_idx = 0;
    char_idx = 0;
    mismatches = 0;
    failures = 0;
    read_input_file();
    loaded = 1'b1;
    repeat (8) begin
      @(negedge clk);
      compare_value("mem valid during reset", 64'd0, 64'(mem_valid));
      compare_value("putch valid during reset", 64'd0, 64'(putch_valid));
    end
    i_rst = 1'b0;
    wait (all_seen);
    // a few more cycles to catch stray stores
    repeat (16) @(negedge clk);
    print_summary();
    if (mismatches == 0 && failures == 0 && i_cpu_top.u_chk.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (loaded);
    limit = 64 * (n_prog + exp_store_addr.size() + exp_char.size()) + 8;
    repeat (limit) @(posedge clk);
    $display("timeout: the program did not finish within %0d cycles", limit);
    print_summary();
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* testbench/cpu_chk.sv */
// protocol checks on the core memory bus and character output, bound into cpu_top
`default_nettype none

module cpu_chk (
  input  logic               clk,
  input  logic               i_rst,
  input  logic               i_mem_valid,
  input  core_pkg::mem_req_t i_mem_req,
  input  logic               i_mem_ready,
  input  logic               i_putch_valid
);
  import core_pkg::*;

  // number of failed assertions
  int unsigned fail_count = 0;

  //////////////////////////////
  // memory bus hold rules

  assert property (@(posedge clk) disable iff (i_rst)
    (i_mem_valid && !i_mem_ready) |=> $stable(i_mem_req))
    else begin
      $error("memory request changed while waiting for ready");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (i_rst)
    (i_mem_valid && !i_mem_ready) |=> i_mem_valid)
    else begin
      $error("memory valid dropped before ready");
      fail_count++;
    end

  //////////////////////////////
  // character output

  // second reset cycle onward, outputs are defined by then
  assert property (@(posedge clk)
    (i_rst && $past(i_rst)) |-> !i_putch_valid)
    else begin
      $error("character output active during reset");
      fail_count++;
    end

endmodule

`default_nettype wire

/* testbench/clock_gen.sv */
// free-running testbench clock, period of 10 time units, starts low
`default_nettype none

module clock_gen (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    // half period
    forever begin
      #5 o_clk = ~o_clk;
    end
  end

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
// top level of the multi-cycle RV64 core, connects the stages to one memory port
`default_nettype none
`include "core_macros.svh"

module cpu_top (
  input  logic               clk,
  input  logic               i_rst,
  output logic               o_mem_valid,
  output core_pkg::mem_req_t o_mem_req,
  input  logic               i_mem_ready,
  input  logic [`XLEN-1:0]   i_mem_rdata,
  output logic               o_putch_valid,
  output logic [7:0]         o_putch_char
);

  // fetch and data ports toward the arbiter
  logic               f_valid;
  core_pkg::mem_req_t f_req;
  logic               f_ready;
  logic               d_valid;
  core_pkg::mem_req_t d_req;
  logic               d_ready;
  logic [`XLEN-1:0]   bus_rdata;

  // stage handshake
  logic               fetched_req;
  logic               fetched_ack;
  logic               retired;
  logic [`XLEN-1:0]   next_pc;
  logic [`XLEN-1:0]   pc;
  core_pkg::inst_t    inst;
  core_pkg::uop_t     uop;

  // register file
  logic [`XLEN-1:0]   rs1_data;
  logic [`XLEN-1:0]   rs2_data;
  logic               rd_wen;
  logic [`REG_AW-1:0] rd;
  logic [`XLEN-1:0]   rd_wdata;

  // execute to load/store
  logic               ls_start;
  logic               ls_write;
  logic [`XLEN-1:0]   ls_addr;
  logic [`XLEN-1:0]   ls_wdata;
  logic               ls_done;
  logic [`XLEN-1:0]   ls_rdata;

  fetch_unit u_fetch (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_retired     (retired),
    .i_next_pc     (next_pc),
    .o_f_valid     (f_valid),
    .o_f_req       (f_req),
    .i_f_ready     (f_ready),
    .i_f_rdata     (bus_rdata),
    .o_fetched_req (fetched_req),
    .i_fetched_ack (fetched_ack),
    .o_pc          (pc),
    .o_inst        (inst)
  );

  decoder u_decoder (
    .i_inst (inst),
    .o_uop  (uop)
  );

  regfile u_regfile (
    .clk        (clk),
    .i_rst      (i_rst),
    .i_rs1      (uop.rs1),
    .i_rs2      (uop.rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .i_wen      (rd_wen),
    .i_rd       (rd),
    .i_wdata    (rd_wdata)
  );

  exec_unit u_exec (
    .clk           (clk),
    .i_rst         (i_rst),
    .i_fetched_req (fetched_req),
    .o_fetched_ack (fetched_ack),
    .i_pc          (pc),
    .i_uop         (uop),
    .i_rs1_data    (rs1_data),
    .i_rs2_data    (rs2_data),
    .o_rd_wen      (rd_wen),
    .o_rd          (rd),
    .o_rd_wdata    (rd_wdata),
    .o_ls_start    (ls_start),
    .o_ls_write    (ls_write),
    .o_ls_addr     (ls_addr),
    .o_ls_wdata    (ls_wdata),
    .i_ls_done     (ls_done),
    .i_ls_rdata    (ls_rdata),
    .o_retired     (retired),
    .o_next_pc     (next_pc),
    .o_putch_valid (o_putch_valid),
    .o_putch_char  (o_putch_char)
  );

  load_store_unit u_lsu (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_start   (ls_start),
    .i_write   (ls_write),
    .i_addr    (ls_addr),
    .i_wdata   (ls_wdata),
    .o_d_valid (d_valid),
    .o_d_req   (d_req),
    .i_d_ready (d_ready),
    .i_d_rdata (bus_rdata),
    .o_done    (ls_done),
    .o_rdata   (ls_rdata)
  );

  bus_arbiter u_arbiter (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_f_valid   (f_valid),
    .i_f_req     (f_req),
    .o_f_ready   (f_ready),
    .i_d_valid   (d_valid),
    .i_d_req     (d_req),
    .o_d_ready   (d_ready),
    .o_rdata     (bus_rdata),
    .o_mem_valid (o_mem_valid),
    .o_mem_req   (o_mem_req),
    .i_mem_ready (i_mem_ready),
    .i_mem_rdata (i_mem_rdata)
  );

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
// merges fetch and data requests onto the single memory port, data side has priority
`default_nettype none
`include "core_macros.svh"

module bus_arbiter (
  input  logic               clk,
  input  logic               i_rst,
  input  logic               i_f_valid,
  input  core_pkg::mem_req_t i_f_req,
  output logic               o_f_ready,
  input  logic               i_d_valid,
  input  core_pkg::mem_req_t i_d_req,
  output logic               o_d_ready,
  output logic [`XLEN-1:0]   o_rdata,
  output logic               o_mem_valid,
  output core_pkg::mem_req_t o_mem_req,
  input  logic               i_mem_ready,
  input  logic [`XLEN-1:0]   i_mem_rdata
);
  import core_pkg::*;

  logic     busy_q;
  logic     grant_d_q;
  logic     sel_d;
  mem_req_t sel_req;

  // locked grant wins while a transfer is stalled
  assign sel_d   = busy_q ? grant_d_q : i_d_valid;
  assign sel_req = sel_d ? i_d_req : i_f_req;

  assign o_mem_valid = sel_d ? i_d_valid : i_f_valid;
  assign o_mem_req   = sel_req;

  assign o_f_ready = !sel_d && i_f_valid && i_mem_ready;
  assign o_d_ready = sel_d && i_d_valid && i_mem_ready;

  // read data goes to both, ready picks the owner
  assign o_rdata = i_mem_rdata;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      busy_q    <= 1'b0;
      grant_d_q <= 1'b0;
    end else if (o_mem_valid && !i_mem_ready) begin
      busy_q    <= 1'b1;
      grant_d_q <= sel_d;
    end else if (i_mem_ready) begin
      busy_q <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* hw/regfile.sv */
// integer register file, two combinational read ports and one write port, x0 fixed at zero
`default_nettype none
`include "core_macros.svh"

module regfile (
  input  logic               clk,
  input  logic               i_rst,
  input  logic [`REG_AW-1:0] i_rs1,
  input  logic [`REG_AW-1:0] i_rs2,
  output logic [`XLEN-1:0]   o_rs1_data,
  output logic [`XLEN-1:0]   o_rs2_data,
  input  logic               i_wen,
  input  logic [`REG_AW-1:0] i_rd,
  input  logic [`XLEN-1:0]   i_wdata
);

  logic [`XLEN-1:0] regs [`NREGS];

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int k = 0; k < `NREGS; k++) begin
        regs[k] <= '0;
      end
    end else if (i_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

endmodule

`default_nettype wire

/* hw/load_store_unit.sv */
// doubleword load/store port: issues one data request per start and returns load data
`default_nettype none
`include "core_macros.svh"

module load_store_unit (
  input  logic               clk,
  input  logic               i_rst,
  input  logic               i_start,
  input  logic               i_write,
  input  logic [`XLEN-1:0]   i_addr,
  input  logic [`XLEN-1:0]   i_wdata,
  output logic               o_d_valid,
  output core_pkg::mem_req_t o_d_req,
  input  logic               i_d_ready,
  input  logic [`XLEN-1:0]   i_d_rdata,
  output logic               o_done,
  output logic [`XLEN-1:0]   o_rdata
);
  import core_pkg::*;

  mem_req_t req_q;

  assign o_d_req = req_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_d_valid <= 1'b0;
      o_done    <= 1'b0;
    end else begin
      o_done <= 1'b0;
      if (i_start) begin
        o_d_valid <= 1'b1;
      end else if (o_d_valid && i_d_ready) begin
        o_d_valid <= 1'b0;
        o_done    <= 1'b1;
      end
    end
  end

  // doubleword only, low address bits dropped
  always_ff @(posedge clk) begin
    if (i_start) begin
      req_q <= '{write: i_write, addr: {i_addr[`XLEN-1:3], 3'b000}, wdata: i_wdata};
    end
    if (o_d_valid && i_d_ready) begin
      o_rdata <= i_d_rdata;
    end
  end

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
// execute stage: ALU, branch and jump resolution, load/store sequencing and retire
`default_nettype none
`include "core_macros.svh"

module exec_unit (
  input  logic               clk,
  input  logic               i_rst,
  input  logic               i_fetched_req,
  output logic               o_fetched_ack,
  input  logic [`XLEN-1:0]   i_pc,
  input  core_pkg::uop_t     i_uop,
  input  logic [`XLEN-1:0]   i_rs1_data,
  input  logic [`XLEN-1:0]   i_rs2_data,
  output logic               o_rd_wen,
  output logic [`REG_AW-1:0] o_rd,
  output logic [`XLEN-1:0]   o_rd_wdata,
  output logic               o_ls_start,
  output logic               o_ls_write,
  output logic [`XLEN-1:0]   o_ls_addr,
  output logic [`XLEN-1:0]   o_ls_wdata,
  input  logic               i_ls_done,
  input  logic [`XLEN-1:0]   i_ls_rdata,
  output logic               o_retired,
  output logic [`XLEN-1:0]   o_next_pc,
  output logic               o_putch_valid,
  output logic [7:0]         o_putch_char
);
  import core_pkg::*;

  typedef enum logic [1:0] {S_IDLE, S_EXEC, S_WAIT_MEM} state_e;

  state_e           state;
  logic [`XLEN-1:0] op_b;
  logic [`XLEN-1:0] alu_res;
  logic [`XLEN-1:0] link_pc;
  logic [`XLEN-1:0] next_pc;
  logic             taken;
  logic             is_mem;
  logic             wen_q;
  logic             putch_q;

  //////////////////////////////
  // datapath

  assign op_b = i_uop.use_imm ? i_uop.imm : i_rs2_data;

  always_comb begin
    case (i_uop.alu_op)
      ALU_SUB:    alu_res = i_rs1_data - op_b;
      ALU_AND:    alu_res = i_rs1_data & op_b;
      ALU_OR:     alu_res = i_rs1_data | op_b;
      ALU_XOR:    alu_res = i_rs1_data ^ op_b;
      ALU_SLT:    alu_res = {63'd0, $signed(i_rs1_data) < $signed(op_b)};
      ALU_PASS_B: alu_res = op_b;
      default:    alu_res = i_rs1_data + op_b;
    endcase
  end

  assign taken   = i_uop.is_branch && (i_uop.branch_ne ^ (i_rs1_data == i_rs2_data));
  assign link_pc = i_pc + 64'd4;
  assign next_pc = (taken || i_uop.is_jal) ? i_pc + i_uop.imm : link_pc;
  assign is_mem  = i_uop.is_load || i_uop.is_store;

  //////////////////////////////
  // control

  assign o_fetched_ack = (state == S_IDLE) && i_fetched_req;
  assign o_rd_wen      = o_retired && wen_q;
  assign o_putch_valid = o_retired && putch_q;

  // exec is the retire cycle
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state      <= S_IDLE;
      o_retired  <= 1'b0;
      o_ls_start <= 1'b0;
    end else begin
      o_retired  <= 1'b0;
      o_ls_start <= 1'b0;
      case (state)
        S_IDLE: begin
          if (o_fetched_ack) begin
            o_ls_start <= is_mem;
            o_retired  <= !is_mem;
            state      <= is_mem ? S_WAIT_MEM : S_EXEC;
          end
        end
        S_WAIT_MEM: begin
          if (i_ls_done) begin
            o_retired <= 1'b1;
            state     <= S_EXEC;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // results captured at ack, load data replaces them on done
  always_ff @(posedge clk) begin
    if (o_fetched_ack) begin
      o_rd         <= i_uop.rd;
      wen_q        <= i_uop.rd_wen;
      putch_q      <= i_uop.is_putch;
      o_rd_wdata   <= i_uop.is_jal ? link_pc : alu_res;
      o_next_pc    <= next_pc;
      o_putch_char <= i_rs1_data[7:0];
      o_ls_write   <= i_uop.is_store;
      o_ls_addr    <= alu_res;
      o_ls_wdata   <= i_rs2_data;
    end else if (i_ls_done) begin
      o_rd_wdata <= i_ls_rdata;
    end
  end

endmodule

`default_nettype wire

/* hw/decoder.sv */
// combinational decode of one instruction word into a micro-operation for execute
`default_nettype none
`include "core_macros.svh"

module decoder (
  input  core_pkg::inst_t i_inst,
  output core_pkg::uop_t  o_uop
);
  import core_pkg::*;

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] imm_j;
  logic [`XLEN-1:0] imm_u;

  //////////////////////////////
  // immediates

  assign imm_i = {{52{i_inst.i.imm[11]}}, i_inst.i.imm};
  assign imm_s = {{52{i_inst.i.imm[11]}}, i_inst.i.imm[11:5], i_inst.i.rd};
  assign imm_b = {{52{i_inst.i.imm[11]}}, i_inst.i.rd[0], i_inst.i.imm[10:5],
                  i_inst.i.rd[4:1], 1'b0};
  assign imm_j = {{44{i_inst.i.imm[11]}}, i_inst.i.rs1, i_inst.i.funct3,
                  i_inst.i.imm[0], i_inst.i.imm[10:1], 1'b0};
  assign imm_u = {{32{i_inst.i.imm[11]}}, i_inst.i.imm, i_inst.i.rs1,
                  i_inst.i.funct3, 12'h000};

  //////////////////////////////
  // opcode decode

  always_comb begin
    o_uop     = '0;
    o_uop.rs1 = i_inst.r.rs1;
    o_uop.rs2 = i_inst.r.rs2;
    o_uop.rd  = i_inst.r.rd;
    case (i_inst.r.opcode)
      `OP_LUI: begin
        o_uop.rd_wen  = 1'b1;
        o_uop.use_imm = 1'b1;
        o_uop.imm     = imm_u;
        o_uop.alu_op  = ALU_PASS_B;
      end
      `OP_OPIMM: begin
        // only addi
        o_uop.rd_wen  = (i_inst.i.funct3 == 3'b000);
        o_uop.use_imm = 1'b1;
        o_uop.imm     = imm_i;
      end
      `OP_OP: begin
        o_uop.rd_wen = 1'b1;
        case (i_inst.r.funct3)
          3'b000:  o_uop.alu_op = i_inst.r.funct7[5] ? ALU_SUB : ALU_ADD;
          3'b010:  o_uop.alu_op = ALU_SLT;
          3'b100:  o_uop.alu_op = ALU_XOR;
          3'b110:  o_uop.alu_op = ALU_OR;
          3'b111:  o_uop.alu_op = ALU_AND;
          default: o_uop.rd_wen = 1'b0;
        endcase
      end
      `OP_BRANCH: begin
        o_uop.is_branch = (i_inst.r.funct3[2:1] == 2'b00);
        o_uop.branch_ne = i_inst.r.funct3[0];
        o_uop.imm       = imm_b;
      end
      `OP_JAL: begin
        o_uop.is_jal = 1'b1;
        o_uop.rd_wen = 1'b1;
        o_uop.imm    = imm_j;
      end
      `OP_LOAD: begin
        o_uop.is_load = (i_inst.i.funct3 == 3'b011);
        o_uop.rd_wen  = (i_inst.i.funct3 == 3'b011);
        o_uop.use_imm = 1'b1;
        o_uop.imm     = imm_i;
      end
      `OP_STORE: begin
        o_uop.is_store = (i_inst.i.funct3 == 3'b011);
        o_uop.use_imm  = 1'b1;
        o_uop.imm      = imm_s;
      end
      default: begin
        o_uop.rd_wen = 1'b0;
      end
    endcase
    // putch reads a0
    if (i_inst == `PUTCH_INST) begin
      o_uop.is_putch = 1'b1;
      o_uop.rs1      = 5'd10;
    end
  end

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
// fetch stage: holds the pc, reads one instruction per retire and hands it to execute
`default_nettype none
`include "core_macros.svh"

module fetch_unit (
  input  logic              clk,
  input  logic              i_rst,
  input  logic              i_retired,
  input  logic [`XLEN-1:0]  i_next_pc,
  output logic              o_f_valid,
  output core_pkg::mem_req_t o_f_req,
  input  logic              i_f_ready,
  input  logic [`XLEN-1:0]  i_f_rdata,
  output logic              o_fetched_req,
  input  logic              i_fetched_ack,
  output logic [`XLEN-1:0]  o_pc,
  output core_pkg::inst_t   o_inst
);
  import core_pkg::*;

  // one-shot kick for the first fetch after reset
  logic             boot_q;
  logic [`ILEN-1:0] half;

  // aligned doubleword read, pc only moves while no request is out
  assign o_f_req = '{write: 1'b0, addr: {o_pc[`XLEN-1:3], 3'b000}, wdata: '0};

  assign half = o_pc[2] ? i_f_rdata[2*`ILEN-1:`ILEN] : i_f_rdata[`ILEN-1:0];

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_pc          <= `RESET_PC;
      boot_q        <= 1'b1;
      o_f_valid     <= 1'b0;
      o_fetched_req <= 1'b0;
    end else begin
      boot_q <= 1'b0;
      if (boot_q || i_retired) begin
        o_f_valid <= 1'b1;
      end else if (i_f_ready) begin
        o_f_valid <= 1'b0;
      end
      if (i_retired) begin
        o_pc <= i_next_pc;
      end
      if (o_f_valid && i_f_ready) begin
        o_fetched_req <= 1'b1;
      end else if (i_fetched_ack) begin
        o_fetched_req <= 1'b0;
      end
    end
  end

  // held until the next transfer, execute reads it through the decoder
  always_ff @(posedge clk) begin
    if (o_f_valid && i_f_ready) begin
      o_inst <= inst_t'(half);
    end
  end

endmodule

`default_nettype wire

/* hw/core_pkg.sv */
// shared core types: instruction views, micro-operation and memory request, imported by RTL
`default_nettype none
`include "core_macros.svh"

package core_pkg;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } rtype_t;

  // imm[4:0] overlays rs2, imm[11:5] overlays funct7
  typedef struct packed {
    logic [11:0]        imm;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } itype_t;

  typedef union packed {
    rtype_t r;
    itype_t i;
  } inst_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    alu_op_e            alu_op;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic               rd_wen;
    logic [`XLEN-1:0]   imm;
    logic               use_imm;
    logic               is_load;
    logic               is_store;
    logic               is_branch;
    logic               branch_ne;
    logic               is_jal;
    logic               is_putch;
  } uop_t;

  typedef struct packed {
    logic               write;
    logic [`XLEN-1:0]   addr;
    logic [`XLEN-1:0]   wdata;
  } mem_req_t;

endpackage

`default_nettype wire

/* include/core_macros.svh */
// core widths, reset address and opcode constants, included by RTL and testbench files
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and instruction widths
`define XLEN        64
`define ILEN        32

// register file geometry
`define REG_AW      5
`define NREGS       32

// first fetch address after reset
`define RESET_PC    64'h0000_0000_0000_0000

// custom word that emits the low byte of x10
`define PUTCH_INST  32'h0000_007b

// major opcodes, bits [6:0]
`define OP_LUI      7'b0110111
`define OP_OPIMM    7'b0010011
`define OP_OP       7'b0110011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011

`endif
